// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and address width
`define XLEN 32

// architectural register count, x0 included
`define NUM_REGS 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: logic/rv_pkg.sv
`include "core_config.svh"

package rv_pkg;

    localparam int REG_AW = $clog2(`NUM_REGS);

    typedef logic [REG_AW-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0]  word_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,  // add, sub
        op_imm   = 7'b0010011,  // addi
        op_load  = 7'b0000011,  // lw
        op_store = 7'b0100011,  // sw
        op_jalr  = 7'b1100111
    } opcode_e;

    // writeback source, sel_none only ever marks a store
    typedef enum logic [1:0] {
        sel_alu  = 2'd0,
        sel_pc4  = 2'd1,
        sel_none = 2'd2,
        sel_load = 2'd3
    } sel_data_e;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;       // zero for register ops
        reg_idx_t  rs1;       // zero when the operand is unused
        reg_idx_t  rs2;
        reg_idx_t  rd;
        logic      wr_en;
        sel_data_e sel_data;
        logic      is_store;
        logic      sub;
    } id_exe_t;

    typedef struct packed {
        word_t     result;      // alu value or memory address
        word_t     store_data;
        reg_idx_t  rd;
        logic      wr_en;
        sel_data_e sel_data;
    } exe_mem_t;

endpackage

// File: logic/hazard_if.sv
// exe stage load info and load-use flags shared by decode, execute and the controller
interface hazard_if;

    rv_pkg::sel_data_e exe_sel_data;
    logic              exe_wr_en;
    rv_pkg::reg_idx_t  exe_rd;
    logic              fw_mem_to_exe_a;  // id rs1 waits on a load in exe
    logic              fw_mem_to_exe_b;  // same for rs2

    modport exe_side (output exe_sel_data, exe_wr_en, exe_rd);

    modport dec_side (
        input  exe_sel_data, exe_wr_en, exe_rd,
        output fw_mem_to_exe_a, fw_mem_to_exe_b
    );

    modport ctrl_side (input exe_sel_data, exe_wr_en, exe_rd, fw_mem_to_exe_a, fw_mem_to_exe_b);

endinterface

// File: logic/fetch_decode.sv
`include "core_config.svh"

module fetch_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`XLEN-1:0]     inst_data,
    input  logic                 if_en,
    input  logic                 id_en,
    input  rv_pkg::reg_idx_t     mem_fw_rd,
    input  logic [`XLEN-1:0]     mem_fw_data,
    input  logic                 mem_fw_valid,
    input  rv_pkg::reg_idx_t     wb_rd,
    input  logic [`XLEN-1:0]     wb_data,
    input  logic                 wb_wr_en,
    input  logic [`XLEN-1:0]     exe_result,   // for jalr forwarding
    output logic [`XLEN-1:0]     inst_addr,
    output rv_pkg::id_exe_t      id_exe,
    output logic [`XLEN-1:0]     id_inst,
    hazard_if.dec_side           hz
);

    localparam logic [`XLEN-1:0] NOP = `XLEN'(32'h0000_0013);  // addi x0, x0, 0

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] id_pc;
    logic [`XLEN-1:0] regs [`NUM_REGS];
    rv_pkg::opcode_e  opcode;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] jalr_base;
    logic [`XLEN-1:0] jalr_sum;
    logic             jalr_taken;
    logic             exe_load;

    // x0 reads zero, a same-cycle wb write wins over the array
    function automatic logic [`XLEN-1:0] rf_read(input rv_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb_wr_en && wb_rd == idx)
            return wb_data;
        return regs[idx];
    endfunction

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RESET_PC;
        else if (if_en)
            pc <= jalr_taken ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + `XLEN'(4);
    end

    // if/id, the fetch behind a taken jalr is squashed
    always_ff @(posedge clk) begin
        if (reset)
            id_inst <= NOP;
        else if (id_en)
            id_inst <= jalr_taken ? NOP : inst_data;
    end

    always_ff @(posedge clk) begin
        if (id_en)
            id_pc <= pc;
    end

    always_ff @(posedge clk) begin
        if (wb_wr_en && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    assign opcode = rv_pkg::opcode_e'(id_inst[6:0]);
    assign rd     = id_inst[11:7];
    assign rs1    = id_inst[19:15];
    assign rs2    = id_inst[24:20];
    assign imm_i  = {{(`XLEN-12){id_inst[31]}}, id_inst[31:20]};
    assign imm_s  = {{(`XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};

    always_comb begin
        id_exe          = '0;        // unknown opcodes decode to a bubble
        id_exe.pc       = id_pc;
        id_exe.rd       = rd;
        id_exe.imm      = imm_i;
        id_exe.sel_data = rv_pkg::sel_alu;
        case (opcode)
            rv_pkg::op_reg: begin
                id_exe.rs1   = rs1;
                id_exe.rs2   = rs2;
                id_exe.imm   = '0;
                id_exe.wr_en = 1'b1;
                id_exe.sub   = id_inst[30];  // funct7 bit picks sub
            end
            rv_pkg::op_imm: begin
                id_exe.rs1   = rs1;
                id_exe.wr_en = 1'b1;
            end
            rv_pkg::op_load: begin
                id_exe.rs1      = rs1;
                id_exe.wr_en    = 1'b1;
                id_exe.sel_data = rv_pkg::sel_load;
            end
            rv_pkg::op_store: begin
                id_exe.rs1      = rs1;
                id_exe.rs2      = rs2;
                id_exe.imm      = imm_s;
                id_exe.is_store = 1'b1;
                id_exe.sel_data = rv_pkg::sel_none;
            end
            rv_pkg::op_jalr: begin
                // target resolved here, exe only produces the link value
                id_exe.wr_en    = 1'b1;
                id_exe.sel_data = rv_pkg::sel_pc4;
            end
            default: ;
        endcase
        if (rd == '0)
            id_exe.wr_en = 1'b0;
        id_exe.rs1_val = rf_read(id_exe.rs1);
        id_exe.rs2_val = rf_read(id_exe.rs2);
    end

    // jalr base, youngest producer wins
    always_comb begin
        jalr_base = rf_read(rs1);
        if (mem_fw_valid && mem_fw_rd == rs1)
            jalr_base = mem_fw_data;
        if (hz.exe_wr_en && hz.exe_rd == rs1 && hz.exe_sel_data != rv_pkg::sel_load)
            jalr_base = exe_result;
    end

    assign jalr_sum   = jalr_base + imm_i;
    assign jalr_taken = (opcode == rv_pkg::op_jalr);

    // load in exe feeding an id operand, jalr excluded since its rs1 slot is zero
    assign exe_load = hz.exe_wr_en && hz.exe_sel_data == rv_pkg::sel_load;
    assign hz.fw_mem_to_exe_a = exe_load && id_exe.rs1 != '0 && id_exe.rs1 == hz.exe_rd;
    assign hz.fw_mem_to_exe_b = exe_load && id_exe.rs2 != '0 && id_exe.rs2 == hz.exe_rd;

    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_addr[1:0] == 2'b00);

endmodule

// File: logic/execute.sv
`include "core_config.svh"

module execute (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pkg::id_exe_t      id_exe,
    input  logic                 exe_en,
    input  logic                 exe_jalr_stall,
    input  logic                 mem_en,
    input  rv_pkg::reg_idx_t     mem_fw_rd,
    input  logic [`XLEN-1:0]     mem_fw_data,
    input  logic                 mem_fw_valid,
    input  rv_pkg::reg_idx_t     wb_rd,
    input  logic [`XLEN-1:0]     wb_data,
    input  logic                 wb_wr_en,
    output rv_pkg::exe_mem_t     exe_mem,
    output logic [`XLEN-1:0]     exe_result,
    hazard_if.exe_side           hz
);

    rv_pkg::id_exe_t  q;          // id/exe register
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b_reg;   // forwarded rs2, also the store data
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu;
    logic             fw_a_mem;
    logic             fw_a_wb;
    logic             fw_b_mem;
    logic             fw_b_wb;
    logic             mem_load;   // the instruction now in mem is a load

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (!mem_en) begin
            // operands follow the wb drain while the bus holds the pipe
            q.rs1_val <= op_a;
            q.rs2_val <= op_b_reg;
        end else if (!exe_en || exe_jalr_stall) begin
            q <= '0;                              // bubble
        end else begin
            q <= id_exe;
        end
    end

    // follows the exe/mem register
    always_ff @(posedge clk) begin
        if (reset)
            mem_load <= 1'b0;
        else if (mem_en)
            mem_load <= q.wr_en && q.sel_data == rv_pkg::sel_load;
    end

    // wr_en never set for rd 0, so x0 never matches
    assign fw_a_mem = mem_fw_valid && mem_fw_rd == q.rs1;
    assign fw_a_wb  = wb_wr_en && wb_rd == q.rs1;
    assign fw_b_mem = mem_fw_valid && mem_fw_rd == q.rs2;
    assign fw_b_wb  = wb_wr_en && wb_rd == q.rs2;

    assign op_a     = fw_a_mem ? mem_fw_data : (fw_a_wb ? wb_data : q.rs1_val);
    assign op_b_reg = fw_b_mem ? mem_fw_data : (fw_b_wb ? wb_data : q.rs2_val);

    // reg ops carry imm 0 and imm ops carry rs2 = x0, so one adder input serves both
    assign op_b = q.is_store ? q.imm : op_b_reg + q.imm;
    assign alu  = q.sub ? op_a - op_b : op_a + op_b;

    assign exe_result = (q.sel_data == rv_pkg::sel_pc4) ? q.pc + `XLEN'(4) : alu;

    always_comb begin
        exe_mem.result     = exe_result;
        exe_mem.store_data = op_b_reg;
        exe_mem.rd         = q.rd;
        exe_mem.wr_en      = q.wr_en;
        exe_mem.sel_data   = q.sel_data;
    end

    assign hz.exe_sel_data = q.sel_data;
    assign hz.exe_wr_en    = q.wr_en;
    assign hz.exe_rd       = q.rd;

    // the load-use stall keeps a load's consumer out of exe for the whole bus access
    a_no_load_fw: assert property (@(posedge clk) disable iff (reset)
        mem_load |-> !(fw_a_mem || fw_b_mem));

endmodule

// File: logic/mem_wb.sv
`include "core_config.svh"

module mem_wb (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_pkg::exe_mem_t       exe_mem,
    input  logic                   mem_en,
    input  logic [`XLEN-1:0]       wb_dat_r,
    input  logic                   wb_ack,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [`XLEN-1:0]       wb_adr,
    output logic [`XLEN-1:0]       wb_dat_w,
    output logic [`XLEN/8-1:0]     wb_sel,
    output logic                   mem_wait,
    output rv_pkg::reg_idx_t       mem_fw_rd,
    output logic [`XLEN-1:0]       mem_fw_data,
    output logic                   mem_fw_valid,
    output rv_pkg::reg_idx_t       wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic                   wb_wr_en
);

    rv_pkg::exe_mem_t q;   // exe/mem register
    logic             is_load;
    logic             is_store;

    always_ff @(posedge clk) begin
        if (reset)
            q <= '0;
        else if (mem_en)
            q <= exe_mem;
    end

    assign is_load  = (q.sel_data == rv_pkg::sel_load);
    assign is_store = (q.sel_data == rv_pkg::sel_none);

    // classic cycle, request stays up until ack since the whole pipe is frozen
    assign wb_cyc   = is_load || is_store;
    assign wb_stb   = wb_cyc;
    assign wb_we    = is_store;
    assign wb_adr   = q.result;
    assign wb_dat_w = q.store_data;
    assign wb_sel   = '1;                  // word access only
    assign mem_wait = wb_stb && !wb_ack;

    // load data counts as ready only in its ack cycle
    assign mem_fw_rd    = q.rd;
    assign mem_fw_data  = is_load ? wb_dat_r : q.result;
    assign mem_fw_valid = q.wr_en && (!is_load || wb_ack);

    // a bubble goes into wb while mem waits, so each retire shows once
    always_ff @(posedge clk) begin
        if (reset)
            wb_wr_en <= 1'b0;
        else
            wb_wr_en <= mem_en && q.wr_en;
    end

    always_ff @(posedge clk) begin
        if (mem_en) begin
            wb_rd   <= q.rd;
            wb_data <= mem_fw_data;
        end
    end

    a_stb_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> wb_stb);

    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> $stable(wb_adr) && $stable(wb_we));

endmodule

// File: logic/sf_controller.sv
`include "core_config.svh"

module sf_controller (
    input  logic              clk,        // samples the checks only
    input  logic              reset,
    input  logic              mem_wait,   // open bus request
    input  logic [`XLEN-1:0]  id_inst,
    hazard_if.ctrl_side       hz,
    output logic              if_en,      // pc
    output logic              id_en,      // if/id register
    output logic              exe_en,     // low puts a bubble into id/exe
    output logic              exe_jalr_stall,
    output logic              mem_en      // exe/mem and mem/wb
);

    logic             exe_load;
    logic             jalr_stall;
    logic             load_stall;
    rv_pkg::reg_idx_t id_rs1;

    assign exe_load = hz.exe_wr_en && hz.exe_sel_data == rv_pkg::sel_load;
    assign id_rs1   = id_inst[19:15];

    // jalr needs its base in id, a load in exe is one cycle too late
    assign jalr_stall = exe_load && id_inst[6:0] == rv_pkg::op_jalr && id_rs1 == hz.exe_rd;
    assign load_stall = hz.fw_mem_to_exe_a || hz.fw_mem_to_exe_b;

    // a bus wait overrides everything and holds every stage
    assign if_en          = !(mem_wait || load_stall || jalr_stall);
    assign id_en          = !(mem_wait || load_stall || jalr_stall);
    assign exe_en         = !(mem_wait || load_stall);
    assign exe_jalr_stall = jalr_stall;
    assign mem_en         = !mem_wait;

    a_stall_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(exe_jalr_stall && load_stall));

endmodule

// File: logic/core_top.sv
`include "core_config.svh"

module core_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       inst_data,
    input  logic [`XLEN-1:0]       wb_dat_r,
    input  logic                   wb_ack,
    output logic [`XLEN-1:0]       inst_addr,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [`XLEN-1:0]       wb_adr,
    output logic [`XLEN-1:0]       wb_dat_w,
    output logic [`XLEN/8-1:0]     wb_sel,
    output logic                   retire_valid,
    output rv_pkg::reg_idx_t       retire_rd,
    output logic [`XLEN-1:0]       retire_data
);

    rv_pkg::id_exe_t  id_exe;
    rv_pkg::exe_mem_t exe_mem;
    logic [`XLEN-1:0] id_inst;
    logic [`XLEN-1:0] exe_result;
    logic             if_en;
    logic             id_en;
    logic             exe_en;
    logic             exe_jalr_stall;
    logic             mem_en;
    logic             mem_wait;
    rv_pkg::reg_idx_t mem_fw_rd;
    logic [`XLEN-1:0] mem_fw_data;
    logic             mem_fw_valid;

    hazard_if hz ();

    // the wb stage write is also the retire port
    fetch_decode fetch_decode_i (
        .clk, .reset, .inst_data, .if_en, .id_en,
        .mem_fw_rd, .mem_fw_data, .mem_fw_valid,
        .wb_rd(retire_rd), .wb_data(retire_data), .wb_wr_en(retire_valid),
        .exe_result, .inst_addr, .id_exe, .id_inst,
        .hz(hz.dec_side)
    );

    execute execute_i (
        .clk, .reset, .id_exe, .exe_en, .exe_jalr_stall, .mem_en,
        .mem_fw_rd, .mem_fw_data, .mem_fw_valid,
        .wb_rd(retire_rd), .wb_data(retire_data), .wb_wr_en(retire_valid),
        .exe_mem, .exe_result,
        .hz(hz.exe_side)
    );

    mem_wb mem_wb_i (
        .clk, .reset, .exe_mem, .mem_en, .wb_dat_r, .wb_ack,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .mem_wait,
        .mem_fw_rd, .mem_fw_data, .mem_fw_valid,
        .wb_rd(retire_rd), .wb_data(retire_data), .wb_wr_en(retire_valid)
    );

    sf_controller sf_controller_i (
        .clk, .reset, .mem_wait, .id_inst,
        .hz(hz.ctrl_side),
        .if_en, .id_en, .exe_en, .exe_jalr_stall, .mem_en
    );

endmodule

// File: sim/core_check.sv
`include "core_config.svh"

module core_check (
    input  logic               clk,
    input  logic               reset,
    input  logic               retire_valid,
    input  logic [4:0]         retire_rd,
    input  logic [`XLEN-1:0]   retire_data,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`XLEN-1:0]   wb_adr,
    input  logic [`XLEN-1:0]   wb_dat_w,
    input  logic [`XLEN/8-1:0] wb_sel,
    input  logic               wb_ack,
    output int                 errors,
    output int                 retires_left,
    output logic               done
);

    localparam int N_RETIRE = 16;
    localparam int N_STORE  = 3;

    // retires in program order, the wrong-path x12 writes never appear
    localparam logic [4:0] EXP_RD [N_RETIRE] = '{
        5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8,
        5'd9, 5'd10, 5'd11, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17
    };
    localparam logic [31:0] EXP_VAL [N_RETIRE] = '{
        32'h0000_0005, 32'h0000_000c, 32'h0000_0011, 32'h0000_000c,
        32'hffff_fffb, 32'hffff_fffb, 32'h0000_0011, 32'h0000_0016,
        32'h0000_0048, 32'h0000_0048, 32'h0000_0038, 32'h5a5a_0080,  // link 0x34 + 4
        32'h5a5a_00b8, 32'h5a5a_00b8, 32'h5a5a_00bd, 32'h5a5a_00bc
    };
    localparam logic [31:0] EXP_ST_ADR [N_STORE] = '{32'h40, 32'h44, 32'h4c};
    localparam logic [31:0] EXP_ST_DAT [N_STORE] = '{32'h11, 32'h48, 32'h5a5a_00b8};

    int n_ret;
    int n_st;

    assign retires_left = N_RETIRE - n_ret;
    assign done         = (n_ret == N_RETIRE) && (n_st == N_STORE);

    always @(posedge clk) begin
        if (reset) begin
            n_ret  = 0;
            n_st   = 0;
            errors = 0;
        end else begin
            if (retire_valid && retire_rd == 5'd0) begin
                $display("retire reported for x0 with data %h", retire_data);
                errors++;
            end
            if (retire_valid && n_ret >= N_RETIRE) begin
                $display("unexpected retire of x%0d after the last expected one", retire_rd);
                errors++;
            end else if (retire_valid) begin
                if (retire_rd !== EXP_RD[n_ret]) begin
                    $display("Mismatch retire %0d retire_rd: got %h expected %h",
                             n_ret, retire_rd, EXP_RD[n_ret]);
                    errors++;
                end
                if (retire_data !== EXP_VAL[n_ret]) begin
                    $display("Mismatch retire %0d retire_data: got %h expected %h",
                             n_ret, retire_data, EXP_VAL[n_ret]);
                    errors++;
                end
                n_ret++;
            end
            // stores checked in their ack cycle
            if (wb_cyc && wb_stb && wb_we && wb_ack) begin
                if (n_st >= N_STORE) begin
                    $display("unexpected store to address %h", wb_adr);
                    errors++;
                end else begin
                    if (wb_adr !== EXP_ST_ADR[n_st]) begin
                        $display("Mismatch store %0d wb_adr: got %h expected %h",
                                 n_st, wb_adr, EXP_ST_ADR[n_st]);
                        errors++;
                    end
                    if (wb_dat_w !== EXP_ST_DAT[n_st]) begin
                        $display("Mismatch store %0d wb_dat_w: got %h expected %h",
                                 n_st, wb_dat_w, EXP_ST_DAT[n_st]);
                        errors++;
                    end
                    if (wb_sel !== 4'hf) begin
                        $display("Mismatch store %0d wb_sel: got %h expected %h",
                                 n_st, wb_sel, 4'hf);
                        errors++;
                    end
                    n_st++;
                end
            end
        end
    end

endmodule

// File: sim/core_tb.sv
`include "core_config.svh"

module core_tb;

    localparam int PROG_LEN = 24;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;
    localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

    // rv32i encoders, register and immediate fields cut from int arguments
    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] sub(input int rd, input int rs1, input int rs2);
        return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    // fibonacci lfsr, x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // program, one word per pc slot
    localparam logic [31:0] PROG [PROG_LEN] = '{
        addi(1, 0, 5),  addi(2, 1, 7),   add(3, 1, 2),    sub(4, 3, 1),     // fwd chains
        sub(5, 4, 3),   addi(0, 1, 9),   add(6, 0, 5),    sw(3, 0, 'h40),   // x0 write, read
        lw(7, 0, 'h40), add(8, 7, 1),    addi(9, 0, 72),  sw(9, 0, 'h44),   // load-use
        lw(10, 0, 'h44), jalr(11, 10, 0), addi(12, 0, 1), addi(12, 0, 2),   // jalr to 72
        addi(12, 0, 3), addi(12, 0, 4),  lw(13, 0, 'h80), add(14, 13, 11),
        sw(14, 9, 4),   lw(15, 9, 4),    add(16, 1, 15),  addi(17, 16, -1)  // rs2 load-use
    };

    logic               clk;
    logic               reset = 1'b1;
    logic [`XLEN-1:0]   inst_data;
    logic [`XLEN-1:0]   wb_dat_r = '0;
    logic               wb_ack = 1'b0;
    logic [`XLEN-1:0]   inst_addr;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [`XLEN-1:0]   wb_adr;
    logic [`XLEN-1:0]   wb_dat_w;
    logic [`XLEN/8-1:0] wb_sel;
    logic               retire_valid;
    logic [4:0]         retire_rd;
    logic [`XLEN-1:0]   retire_data;
    logic [31:0]        rom [32];
    logic [31:0]        dmem [64];
    logic [16:0]        lfsr = 17'd95175;
    logic [1:0]         delay;
    logic [1:0]         wait_left;    // cycles still owed on the open request
    logic               busy;
    int                 errors;
    int                 retires_left;
    logic               done;

    core_top core_top_i (.*);

    core_check core_check (
        .clk, .reset, .retire_valid, .retire_rd, .retire_data,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_ack,
        .errors, .retires_left, .done
    );

    // rom fill from the program table, nop past its end
    initial begin
        for (int i = 0; i < 32; i++) begin
            if (i < PROG_LEN)
                rom[i] = PROG[i];
            else
                rom[i] = NOP;
        end
    end

    // fetch answers in the same cycle, anything above the rom window is a nop
    assign inst_data = (inst_addr[`XLEN-1:7] == '0) ? rom[inst_addr[6:2]] : NOP;

    // word memory, each request acked after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
            for (int i = 0; i < 64; i++)
                dmem[i] <= 32'h5a5a_0000 ^ (32'(i) << 2);   // byte address in the low half
        end else if (wb_ack) begin
            wb_ack <= 1'b0;   // master has moved on by now
            busy   <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (busy) begin
                delay = wait_left;
            end else begin
                for (int b = 0; b < 2; b++) begin
                    lfsr  = lfsr_step(lfsr);
                    delay = {delay[0], lfsr[0]};   // one step per bit
                end
            end
            busy <= 1'b1;
            if (delay == 2'd0) begin
                wb_ack <= 1'b1;
                if (wb_we)
                    dmem[wb_adr[7:2]] <= wb_dat_w;
                else
                    wb_dat_r <= dmem[wb_adr[7:2]];
            end else begin
                wait_left <= delay - 2'd1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic end_run(input logic timed_out);
        @(negedge clk);   // checker counts settled
        $display("errors %0d, retires outstanding %0d, timeout %0d",
                 errors, retires_left, timed_out);
        if (errors == 0 && !timed_out)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    initial begin
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        repeat (4) @(posedge clk);   // room for a stray retire to show up
        end_run(1'b0);
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d expected retires never came",
                 TIMEOUT_CYCLES, retires_left);
        end_run(1'b1);
    end

endmodule

// File: tb.f
+incdir+logic
logic/rv_pkg.sv
logic/hazard_if.sv
logic/fetch_decode.sv
logic/execute.sv
logic/mem_wb.sv
logic/sf_controller.sv
logic/core_top.sv
sim/core_check.sv
sim/core_tb.sv

// File: Makefile
# verilator build and run of the core testbench
TOP := core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
